// ==== rtl/fbuf_pkg.sv ====
package fbuf_pkg;

  // Memory geometry
  localparam int ADDR_WIDTH = 4;
  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // Pointers carry one wrap bit above the address so full and empty differ
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // Beat payload
  localparam int DATA_WIDTH = 8;
  localparam int USER_WIDTH = 1;

  // Stored word is {user, last, data}
  localparam int WORD_WIDTH = DATA_WIDTH + 1 + USER_WIDTH;

  // User value on a last beat that marks the frame for discard
  localparam logic [USER_WIDTH-1:0] BAD_FRAME_USER = 1'b1;

  // Width of each saturating frame counter
  localparam int CNT_WIDTH = 16;

endpackage

// ==== rtl/fbuf_ram.sv ====
`timescale 1ns/1ps

module fbuf_ram (
  input  logic                            clk,
  input  logic                            wr_en,
  input  logic [fbuf_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [fbuf_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                            wr_last,
  input  logic [fbuf_pkg::USER_WIDTH-1:0] wr_user,
  input  logic                            rd_en,
  input  logic [fbuf_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [fbuf_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                            rd_last,
  output logic [fbuf_pkg::USER_WIDTH-1:0] rd_user
);

  logic [fbuf_pkg::WORD_WIDTH-1:0] mem [fbuf_pkg::DEPTH];
  logic [fbuf_pkg::WORD_WIDTH-1:0] rd_word;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= {wr_user, wr_last, wr_data};
    end
    if (rd_en) begin
      rd_word <= mem[rd_addr];                   // Output register holds between reads
    end
  end

  assign rd_data = rd_word[fbuf_pkg::DATA_WIDTH-1:0];
  assign rd_last = rd_word[fbuf_pkg::DATA_WIDTH];
  assign rd_user = rd_word[fbuf_pkg::DATA_WIDTH+1 +: fbuf_pkg::USER_WIDTH];

endmodule

// ==== rtl/fbuf_ctrl.sv ====
`timescale 1ns/1ps

module fbuf_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            s_tvalid,
  input  logic                            s_tlast,
  input  logic [fbuf_pkg::USER_WIDTH-1:0] s_tuser,
  output logic                            s_tready,
  output logic                            wr_en,
  output logic [fbuf_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic                            pop_ready,
  output logic                            rd_en,
  output logic [fbuf_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                            frame_good,
  output logic                            frame_bad,
  output logic                            frame_overflow
);

  logic [fbuf_pkg::PTR_WIDTH-1:0] wr_ptr;           // Committed write pointer
  logic [fbuf_pkg::PTR_WIDTH-1:0] wr_ptr_next;
  logic [fbuf_pkg::PTR_WIDTH-1:0] wr_ptr_cur;       // Write pointer inside the open frame
  logic [fbuf_pkg::PTR_WIDTH-1:0] wr_ptr_cur_next;
  logic [fbuf_pkg::PTR_WIDTH-1:0] wr_ptr_vis;       // Committed pointer as seen by the reader
  logic [fbuf_pkg::PTR_WIDTH-1:0] rd_ptr;
  logic                           drop_frame;
  logic                           drop_frame_next;
  logic                           accept;
  logic                           full_cur;
  logic                           full_frame;
  logic                           empty;

  // True when two pointers sit on the same word one wrap apart
  function automatic logic ptr_full(
    input logic [fbuf_pkg::PTR_WIDTH-1:0] a,
    input logic [fbuf_pkg::PTR_WIDTH-1:0] b
  );
    return (a[fbuf_pkg::ADDR_WIDTH] != b[fbuf_pkg::ADDR_WIDTH]) &&
           (a[fbuf_pkg::ADDR_WIDTH-1:0] == b[fbuf_pkg::ADDR_WIDTH-1:0]);
  endfunction

  assign full_cur   = ptr_full(wr_ptr_cur, rd_ptr);   // No free word left for the open frame
  assign full_frame = ptr_full(wr_ptr_cur, wr_ptr);   // The open frame alone fills the memory
  assign empty      = (wr_ptr_vis == rd_ptr);

  // Stall only when older committed frames hold the space
  assign s_tready = !full_cur || full_frame || drop_frame;
  assign accept   = s_tvalid && s_tready;

  assign wr_addr = wr_ptr_cur[fbuf_pkg::ADDR_WIDTH-1:0];
  assign rd_en   = pop_ready && !empty;
  assign rd_addr = rd_ptr[fbuf_pkg::ADDR_WIDTH-1:0];

  always_comb begin
    wr_en           = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_frame_next = drop_frame;
    frame_good      = 1'b0;
    frame_bad       = 1'b0;
    frame_overflow  = 1'b0;

    if (accept) begin
      if (full_cur || full_frame || drop_frame) begin
        // Oversize frame, swallow the rest of it
        drop_frame_next = 1'b1;
        if (s_tlast) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          frame_overflow  = 1'b1;
        end
      end else begin
        wr_en           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_tlast) begin
          if (s_tuser == fbuf_pkg::BAD_FRAME_USER) begin
            wr_ptr_cur_next = wr_ptr;            // Rewind over the bad frame
            frame_bad       = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;     // Commit the frame
            frame_good  = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      wr_ptr_vis <= '0;
      rd_ptr     <= '0;
      drop_frame <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      wr_ptr_vis <= wr_ptr;                      // Reader sees a commit one edge later
      drop_frame <= drop_frame_next;
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/fbuf_out_stage.sv ====
`timescale 1ns/1ps

module fbuf_out_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            rd_en,
  input  logic [fbuf_pkg::DATA_WIDTH-1:0] rd_data,
  input  logic                            rd_last,
  input  logic [fbuf_pkg::USER_WIDTH-1:0] rd_user,
  output logic                            pop_ready,
  output logic [fbuf_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic                            m_tlast,
  output logic [fbuf_pkg::USER_WIDTH-1:0] m_tuser,
  output logic                            m_tvalid,
  input  logic                            m_tready
);

  logic mem_valid;                               // Memory output register holds a word
  logic store_output;

  // Output register can take a new word this cycle
  assign store_output = !m_tvalid || m_tready;

  // The memory register may be refilled once its word moves on
  assign pop_ready = !mem_valid || store_output;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
      m_tvalid  <= 1'b0;
    end else begin
      if (rd_en) begin
        mem_valid <= 1'b1;
      end else if (store_output) begin
        mem_valid <= 1'b0;
      end
      if (store_output) begin
        m_tvalid <= mem_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store_output && mem_valid) begin
      m_tdata <= rd_data;
      m_tlast <= rd_last;
      m_tuser <= rd_user;
    end
  end

endmodule

// ==== rtl/fbuf_stats.sv ====
`timescale 1ns/1ps

module fbuf_stats (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           frame_good,
  input  logic                           frame_bad,
  input  logic                           frame_overflow,
  output logic                           status_good,
  output logic                           status_bad,
  output logic                           status_overflow,
  output logic [fbuf_pkg::CNT_WIDTH-1:0] good_count,
  output logic [fbuf_pkg::CNT_WIDTH-1:0] bad_count,
  output logic [fbuf_pkg::CNT_WIDTH-1:0] overflow_count
);

  // Count up by one on a hit and stick at all ones
  function automatic logic [fbuf_pkg::CNT_WIDTH-1:0] sat_inc(
    input logic [fbuf_pkg::CNT_WIDTH-1:0] count,
    input logic                           hit
  );
    if (hit && !(&count)) begin
      return count + 1'b1;
    end
    return count;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      status_good     <= 1'b0;
      status_bad      <= 1'b0;
      status_overflow <= 1'b0;
      good_count      <= '0;
      bad_count       <= '0;
      overflow_count  <= '0;
    end else begin
      status_good     <= frame_good;
      status_bad      <= frame_bad;
      status_overflow <= frame_overflow;
      good_count      <= sat_inc(good_count, frame_good);
      bad_count       <= sat_inc(bad_count, frame_bad);
      overflow_count  <= sat_inc(overflow_count, frame_overflow);
    end
  end

endmodule

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [fbuf_pkg::DATA_WIDTH-1:0] s_tdata,
  input  logic                            s_tlast,
  input  logic [fbuf_pkg::USER_WIDTH-1:0] s_tuser,
  input  logic                            s_tvalid,
  output logic                            s_tready,
  output logic [fbuf_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic                            m_tlast,
  output logic [fbuf_pkg::USER_WIDTH-1:0] m_tuser,
  output logic                            m_tvalid,
  input  logic                            m_tready,
  output logic                            status_good,
  output logic                            status_bad,
  output logic                            status_overflow,
  output logic [fbuf_pkg::CNT_WIDTH-1:0]  good_count,
  output logic [fbuf_pkg::CNT_WIDTH-1:0]  bad_count,
  output logic [fbuf_pkg::CNT_WIDTH-1:0]  overflow_count
);

  logic                            wr_en;
  logic [fbuf_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic                            rd_en;
  logic [fbuf_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [fbuf_pkg::DATA_WIDTH-1:0] rd_data;
  logic                            rd_last;
  logic [fbuf_pkg::USER_WIDTH-1:0] rd_user;
  logic                            pop_ready;
  logic                            frame_good;
  logic                            frame_bad;
  logic                            frame_overflow;

  fbuf_ctrl i_ctrl (
    .clk            (clk),
    .rst            (rst),
    .s_tvalid       (s_tvalid),
    .s_tlast        (s_tlast),
    .s_tuser        (s_tuser),
    .s_tready       (s_tready),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .pop_ready      (pop_ready),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .frame_good     (frame_good),
    .frame_bad      (frame_bad),
    .frame_overflow (frame_overflow)
  );

  // Input payload goes straight to the write port
  fbuf_ram i_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (s_tdata),
    .wr_last (s_tlast),
    .wr_user (s_tuser),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_last (rd_last),
    .rd_user (rd_user)
  );

  fbuf_out_stage i_out_stage (
    .clk       (clk),
    .rst       (rst),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_last   (rd_last),
    .rd_user   (rd_user),
    .pop_ready (pop_ready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast),
    .m_tuser   (m_tuser),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready)
  );

  fbuf_stats i_stats (
    .clk             (clk),
    .rst             (rst),
    .frame_good      (frame_good),
    .frame_bad       (frame_bad),
    .frame_overflow  (frame_overflow),
    .status_good     (status_good),
    .status_bad      (status_bad),
    .status_overflow (status_overflow),
    .good_count      (good_count),
    .bad_count       (bad_count),
    .overflow_count  (overflow_count)
  );

endmodule

// ==== verification/tb_frame_buffer.sv ====
`timescale 1ns/1ps

module tb_frame_buffer;

  localparam int NUM_ROWS     = 15;
  localparam int MODE_RANDOM  = 1;
  localparam int MODE_HOLD    = 2;
  localparam int OUT_GOOD     = 0;
  localparam int OUT_BAD      = 1;
  localparam int OUT_OVERFLOW = 2;

  // One frame per row and the hold column counts the cycles m_tready stays low
  localparam int ROW_LEN   [NUM_ROWS] = '{1, 5, 16, 4, 6, 20, 3, 2, 3, 4, 4, 5, 7, 3, 8};
  localparam int ROW_FIRST [NUM_ROWS] = '{'h10, 'h20, 'h30, 'h40, 'h50, 'h60, 'h70, 'h80,
                                          'h90, 'ha0, 'hb0, 'hc0, 'hd0, 'he0, 'hf0};
  localparam int ROW_BAD   [NUM_ROWS] = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0};
  localparam int ROW_MODE  [NUM_ROWS] = '{0, 0, 0, 0, 1, 0, 0, 2, 0, 0, 0, 0, 1, 1, 1};
  localparam int ROW_HOLD  [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 80, 0, 0, 0, 0, 0, 0, 0};

  logic                            clk = 1'b0;
  logic                            rst;
  logic [fbuf_pkg::DATA_WIDTH-1:0] s_tdata;
  logic                            s_tlast;
  logic [fbuf_pkg::USER_WIDTH-1:0] s_tuser;
  logic                            s_tvalid;
  logic                            s_tready;
  logic [fbuf_pkg::DATA_WIDTH-1:0] m_tdata;
  logic                            m_tlast;
  logic [fbuf_pkg::USER_WIDTH-1:0] m_tuser;
  logic                            m_tvalid;
  logic                            m_tready;
  logic                            status_good;
  logic                            status_bad;
  logic                            status_overflow;
  logic [fbuf_pkg::CNT_WIDTH-1:0]  good_count;
  logic [fbuf_pkg::CNT_WIDTH-1:0]  bad_count;
  logic [fbuf_pkg::CNT_WIDTH-1:0]  overflow_count;

  logic [fbuf_pkg::WORD_WIDTH-1:0] exp_q [$];       // Expected beats as {user, last, data}
  logic [fbuf_pkg::WORD_WIDTH-1:0] held_word;
  logic                            held = 1'b0;
  int seed = 32'h64ae;
  int rand_mode = 0;
  int hold_until = 0;
  int neg_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int errors = 0;
  int rows_passed = 0;
  int rows_failed = 0;
  int exp_good = 0;
  int exp_bad = 0;
  int exp_overflow = 0;
  int pulse_good = 0;
  int pulse_bad = 0;
  int pulse_overflow = 0;
  int total_stalls = 0;

  always #20 clk = ~clk;

  frame_buffer i_dut (
    .clk             (clk),
    .rst             (rst),
    .s_tdata         (s_tdata),
    .s_tlast         (s_tlast),
    .s_tuser         (s_tuser),
    .s_tvalid        (s_tvalid),
    .s_tready        (s_tready),
    .m_tdata         (m_tdata),
    .m_tlast         (m_tlast),
    .m_tuser         (m_tuser),
    .m_tvalid        (m_tvalid),
    .m_tready        (m_tready),
    .status_good     (status_good),
    .status_bad      (status_bad),
    .status_overflow (status_overflow),
    .good_count      (good_count),
    .bad_count       (bad_count),
    .overflow_count  (overflow_count)
  );

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    errors++;
  endtask

  function automatic int frame_outcome(input int len, input int bad);
    if (len > fbuf_pkg::DEPTH) begin
      return OUT_OVERFLOW;                       // Longer than the whole memory
    end
    return (bad != 0) ? OUT_BAD : OUT_GOOD;
  endfunction

  task automatic compare_beat(input logic [fbuf_pkg::WORD_WIDTH-1:0] word);
    assert (m_tdata == word[fbuf_pkg::DATA_WIDTH-1:0])
      else report_mismatch("m_tdata", word[fbuf_pkg::DATA_WIDTH-1:0], m_tdata);
    assert (m_tlast == word[fbuf_pkg::DATA_WIDTH])
      else report_mismatch("m_tlast", word[fbuf_pkg::DATA_WIDTH], m_tlast);
    assert (m_tuser == word[fbuf_pkg::DATA_WIDTH+1 +: fbuf_pkg::USER_WIDTH])
      else report_mismatch("m_tuser", word[fbuf_pkg::DATA_WIDTH+1 +: fbuf_pkg::USER_WIDTH],
                           m_tuser);
  endtask

  // Back-pressure changes on the falling edge only
  always @(negedge clk) begin : ready_drive
    int r;
    neg_count++;
    if (neg_count <= hold_until) begin
      m_tready = 1'b0;
    end else if (rand_mode != 0) begin
      r = $random(seed);
      m_tready = r[0];
    end else begin
      m_tready = 1'b1;
    end
  end

  always @(posedge clk) begin : monitor
    logic [fbuf_pkg::WORD_WIDTH-1:0] exp_word;
    if (!rst) begin
      if (held) begin
        assert (m_tvalid) else begin
          $display("m_tvalid dropped at %0t while m_tready was low", $time);
          errors++;
        end
        compare_beat(held_word);
      end
      if (m_tvalid && m_tready) begin
        assert (exp_q.size() != 0) else begin
          $display("Output beat at %0t arrived with no frame pending", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          compare_beat(exp_word);
        end
      end
      held      = m_tvalid && !m_tready;
      held_word = {m_tuser, m_tlast, m_tdata};
      pulse_good     += status_good;
      pulse_bad      += status_bad;
      pulse_overflow += status_overflow;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: frames still pending after %0d cycles", cycle_limit);
      $display("Rows passed %0d, rows failed %0d, checks failed %0d",
               rows_passed, rows_failed, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic send_frame(input int row, output int stalls);
    logic [fbuf_pkg::DATA_WIDTH-1:0] data;
    data   = ROW_FIRST[row][fbuf_pkg::DATA_WIDTH-1:0];
    stalls = 0;
    for (int beat = 0; beat < ROW_LEN[row]; beat++) begin
      @(negedge clk);
      s_tvalid = 1'b1;
      s_tdata  = data;
      s_tlast  = (beat == ROW_LEN[row] - 1);
      if (s_tlast) begin
        s_tuser = (ROW_BAD[row] != 0) ? fbuf_pkg::BAD_FRAME_USER : '0;
      end else begin
        s_tuser = beat[0];                       // Odd beats inside a frame carry user set
      end
      while (!s_tready) begin                    // Ready comes from registers and holds to the edge
        stalls++;
        @(negedge clk);
      end
      data = data + 1'b1;
    end
    @(negedge clk);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    s_tuser  = '0;
  endtask

  task automatic run_row(input int row);
    logic [fbuf_pkg::DATA_WIDTH-1:0] data;
    logic [fbuf_pkg::USER_WIDTH-1:0] user;
    logic                            last;
    int outcome;
    int stalls;
    int errors_before;
    errors_before = errors;
    outcome = frame_outcome(ROW_LEN[row], ROW_BAD[row]);
    @(posedge clk);
    rand_mode = (ROW_MODE[row] == MODE_RANDOM);
    if (ROW_MODE[row] == MODE_HOLD) begin
      hold_until = neg_count + ROW_HOLD[row];
    end
    if (outcome == OUT_OVERFLOW) begin
      while (exp_q.size() != 0) begin            // Start the oversize frame on an empty memory
        @(negedge clk);
      end
    end
    data = ROW_FIRST[row][fbuf_pkg::DATA_WIDTH-1:0];
    for (int beat = 0; beat < ROW_LEN[row] && outcome == OUT_GOOD; beat++) begin
      last = (beat == ROW_LEN[row] - 1);
      user = last ? '0 : beat[0];
      exp_q.push_back({user, last, data});
      data = data + 1'b1;
    end
    send_frame(row, stalls);
    exp_good     += (outcome == OUT_GOOD);
    exp_bad      += (outcome == OUT_BAD);
    exp_overflow += (outcome == OUT_OVERFLOW);
    assert (status_good == (outcome == OUT_GOOD))
      else report_mismatch("status_good", outcome == OUT_GOOD, status_good);
    assert (status_bad == (outcome == OUT_BAD))
      else report_mismatch("status_bad", outcome == OUT_BAD, status_bad);
    assert (status_overflow == (outcome == OUT_OVERFLOW))
      else report_mismatch("status_overflow", outcome == OUT_OVERFLOW, status_overflow);
    assert (good_count == exp_good) else report_mismatch("good_count", exp_good, good_count);
    assert (bad_count == exp_bad) else report_mismatch("bad_count", exp_bad, bad_count);
    assert (overflow_count == exp_overflow)
      else report_mismatch("overflow_count", exp_overflow, overflow_count);
    if (outcome == OUT_OVERFLOW) begin
      assert (stalls == 0) else begin
        $display("s_tready stalled the oversize frame for %0d cycles", stalls);
        errors++;
      end
    end
    total_stalls += stalls;
    if (errors == errors_before) begin
      rows_passed++;
    end else begin
      rows_failed++;
    end
    $display("Row %0d: %0d beats, outcome %0d, %0d stall cycles, %s", row, ROW_LEN[row],
             outcome, stalls, (errors == errors_before) ? "ok" : "errors");
  endtask

  initial begin
    rst      = 1'b1;
    s_tvalid = 1'b0;
    s_tdata  = '0;
    s_tlast  = 1'b0;
    s_tuser  = '0;
    m_tready = 1'b1;
    for (int row = 0; row < NUM_ROWS; row++) begin
      cycle_limit += ROW_LEN[row] * 4;
    end
    cycle_limit += 200;
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (!m_tvalid) else report_mismatch("m_tvalid", 0, m_tvalid);
    assert (!status_good && !status_bad && !status_overflow) else begin
      $display("A status pulse was high during reset at %0t", $time);
      errors++;
    end
    assert (good_count == 0 && bad_count == 0 && overflow_count == 0) else begin
      $display("Frame counters were not zero after reset at %0t", $time);
      errors++;
    end
    assert (s_tready) else report_mismatch("s_tready", 1, s_tready);
    rst = 1'b0;
    for (int row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);                   // Any extra beat would show up here
    assert (!m_tvalid) else begin
      $display("Output still valid after every expected beat was seen");
      errors++;
    end
    assert (pulse_good == exp_good) else report_mismatch("status_good", exp_good, pulse_good);
    assert (pulse_bad == exp_bad) else report_mismatch("status_bad", exp_bad, pulse_bad);
    assert (pulse_overflow == exp_overflow)
      else report_mismatch("status_overflow", exp_overflow, pulse_overflow);
    assert (total_stalls > 0) else begin
      $display("s_tready never went low while committed frames filled the memory");
      errors++;
    end
    $display("Rows passed %0d, rows failed %0d, checks failed %0d",
             rows_passed, rows_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/fbuf_pkg.sv
rtl/fbuf_ram.sv
rtl/fbuf_ctrl.sv
rtl/fbuf_out_stage.sv
rtl/fbuf_stats.sv
rtl/frame_buffer.sv
verification/tb_frame_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module tb_frame_buffer \
  -o sim_frame_buffer

./obj_dir/sim_frame_buffer > "$LOG" 2>&1
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
